// File: files.f
audio_pkg.sv
i2s_clock_gen.sv
i2s_rx.sv
i2s_tx.sv
frame_capture.sv
dual_port_ram.sv
mix_sequencer.sv
host_regs.sv
audio_engine.sv
tb_audio_engine.sv

// File: Makefile
# verilator flow for the audio engine testbench

TOP := tb_audio_engine

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f files.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// File: tb_audio_engine.sv
/*
 * testbench for the audio engine
 * drives the i2s inputs and the host bus, checks results against a reference mix
 */
`timescale 1ns/1ps
`default_nettype none

module tb_audio_engine;

    import audio_pkg::*;

    localparam logic [31:0] BASE        = 32'h6000;
    localparam logic [31:0] OFS_LEFT    = 32'h100;
    localparam logic [31:0] OFS_RIGHT   = 32'h104;
    localparam logic [31:0] OFS_STATUS  = 32'h200;
    localparam logic [31:0] OFS_CONTROL = 32'h300;

    logic     ck;
    logic     rst_n;
    bus_req_t bus;
    bus_rsp_t rsp;
    logic     sd_in0;
    logic     sd_in1;
    logic     sck;
    logic     ws;
    logic     sd_out;

    logic [15:0]            lfsr_q;
    int                     tests;
    int                     checks;
    int                     errors;
    int                     test_errs;
    string                  test_name;
    sample_t [CHANNELS-1:0] smp;
    coef_t   [CHANNELS-1:0] w_left;
    coef_t   [CHANNELS-1:0] w_right;
    sample_t                res_l;
    sample_t                res_r;
    logic [31:0]            word;

    audio_engine #(.ADDR(BASE), .DIVIDER(2)) dut_i (
        .ck(ck), .rst_n(rst_n), .bus(bus), .rsp(rsp),
        .sd_in0(sd_in0), .sd_in1(sd_in1), .sck(sck), .ws(ws), .sd_out(sd_out));

    always #4 ck = ~ck;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[14:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // sum of q1.15 products, floor shift by 15, clamp to 16 bits
    function automatic sample_t ref_mix(input sample_t [CHANNELS-1:0] s,
                                        input coef_t [CHANNELS-1:0] w);
        longint sum;
        longint q;
        sum = 0;
        for (int i = 0; i < CHANNELS; i++)
            sum += longint'($signed(s[i])) * longint'($signed(w[i]));
        q = sum >>> 15;
        if (q > 32767)
            return 16'sh7fff;
        else if (q < -32768)
            return 16'sh8000;
        else
            return sample_t'(q[15:0]);
    endfunction

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input logic [1:0] got,
                                input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = errors;
    endtask

    task automatic finish_test();
        tests++;
        if (errors == test_errs)
            $display("test %0d %s: ok", tests, test_name);
        else
            $display("test %0d %s: %0d errors", tests, test_name, errors - test_errs);
    endtask

    // one access with valid held until ready
    task automatic bus_access(input logic [31:0] ofs, input logic [3:0] strb,
                              input logic [31:0] data, output logic [31:0] rdata);
        logic got;
        int   n;
        @(posedge ck);
        #1;
        bus.valid = 1'b1;
        bus.wstrb = strb;
        bus.addr  = BASE + ofs;
        bus.wdata = data;
        rdata = '0;
        got = 1'b0;
        n = 0;
        while (!got && n < 16) begin
            @(posedge ck);
            #1;
            got = rsp.ready;
            n++;
        end
        if (got) begin
            rdata = rsp.rdata;
        end else begin
            errors++;
            $display("bus gave no ready within 16 cycles at offset %h", ofs);
        end
        bus.valid = 1'b0;
        bus.wstrb = '0;
    endtask

    task automatic bus_write(input logic [31:0] ofs, input logic [31:0] data);
        logic [31:0] discard;
        bus_access(ofs, 4'hf, data, discard);
    endtask

    task automatic bus_read(input logic [31:0] ofs, output logic [31:0] data);
        bus_access(ofs, 4'h0, 32'h0, data);
    endtask

    task automatic load_weights(input coef_t [CHANNELS-1:0] wl, input coef_t [CHANNELS-1:0] wr);
        for (int i = 0; i < CHANNELS; i++) begin
            bus_write({27'b0, 1'b0, chan_t'(i), 2'b00}, {{16{wl[i][15]}}, wl[i]});
            bus_write({27'b0, 1'b1, chan_t'(i), 2'b00}, {{16{wr[i][15]}}, wr[i]});
        end
    endtask

    task automatic read_results(output sample_t left, output sample_t right);
        logic [31:0] d;
        bus_read(OFS_LEFT, d);
        left = sample_t'(d[15:0]);
        bus_read(OFS_RIGHT, d);
        right = sample_t'(d[15:0]);
    endtask

    // ws falling marks frame_posn 0
    task automatic wait_frame_start();
        logic prev;
        logic seen;
        int   n;
        prev = ws;
        seen = 1'b0;
        n = 0;
        while (!seen && n < 300) begin
            @(posedge ck);
            #1;
            seen = prev && !ws;
            prev = ws;
            n++;
        end
        if (!seen) begin
            errors++;
            $display("no frame start seen on ws within 300 cycles");
        end
    endtask

    task automatic wait_sck_edge(input logic rising);
        logic prev;
        logic seen;
        int   n;
        prev = sck;
        seen = 1'b0;
        n = 0;
        while (!seen && n < 32) begin
            @(posedge ck);
            #1;
            seen = (sck == rising) && (prev != rising);
            prev = sck;
            n++;
        end
        if (!seen) begin
            errors++;
            $display("sck stopped toggling");
        end
    endtask

    // i2s source driving each bit after the falling sck
    task automatic send_frame(input sample_t [CHANNELS-1:0] s);
        logic [31:0] w0;
        logic [31:0] w1;
        w0 = {s[0], s[1]};
        w1 = {s[2], s[3]};
        wait_frame_start();
        sd_in0 = w0[31];
        sd_in1 = w1[31];
        for (int i = 30; i >= 0; i--) begin
            wait_sck_edge(1'b0);
            sd_in0 = w0[i];
            sd_in1 = w1[i];
        end
    endtask

    task automatic capture_serial(output logic [31:0] w);
        wait_frame_start();
        w = '0;
        for (int i = 0; i < 32; i++) begin
            wait_sck_edge(1'b1);
            w = {w[30:0], sd_out};
        end
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          n;
        st = '0;
        n = 0;
        while (!st[0] && n < 40) begin
            bus_read(OFS_STATUS, st);
            n++;
        end
        if (!st[0]) begin
            errors++;
            $display("mix done never showed up in status");
        end
    endtask

    task automatic run_mix(input sample_t [CHANNELS-1:0] s, output sample_t left,
                           output sample_t right);
        send_frame(s);
        // done from earlier frames is stale by now
        bus_write(OFS_STATUS, 32'd1);
        wait_done();
        read_results(left, right);
    endtask

    // sd_out watched over two whole frames
    task automatic watch_idle();
        logic prev;
        logic high_seen;
        int   falls;
        int   n;
        prev = ws;
        high_seen = 1'b0;
        falls = 0;
        n = 0;
        while (falls < 2 && n < 400) begin
            @(posedge ck);
            #1;
            if (sd_out !== 1'b0 && !high_seen) begin
                high_seen = 1'b1;
                errors++;
                $display("ERR %0t sd_out got %b expected 0", $time, sd_out);
            end
            if (prev && !ws)
                falls++;
            prev = ws;
            n++;
        end
        if (falls < 2) begin
            errors++;
            $display("ws did not mark two frames while idle");
        end
    endtask

    initial begin
        ck = 1'b0;
        rst_n = 1'b0;
        bus = '0;
        sd_in0 = 1'b0;
        sd_in1 = 1'b0;
        lfsr_q = 16'd61;
        tests = 0;
        checks = 0;
        errors = 0;
        repeat (8) @(posedge ck);
        #1;
        rst_n = 1'b1;

        start_test("reset state");
        bus_read(OFS_STATUS, word);
        check_status("status", word[1:0], 2'b00);
        read_results(res_l, res_r);
        check_sample("left result", res_l, '0);
        check_sample("right result", res_r, '0);
        watch_idle();
        bus_read(OFS_STATUS, word);
        check_status("status while disabled", word[1:0], 2'b00);
        finish_test();

        start_test("unity routing");
        w_left = '0;
        w_right = '0;
        // 0x7fff is one lsb under unity and still exact for negative samples
        w_left[0] = 16'sh7fff;
        w_right[3] = 16'sh7fff;
        load_weights(w_left, w_right);
        bus_write(OFS_CONTROL, 32'd1);
        smp[0] = -16'sd1234;
        smp[1] = 16'sd5000;
        smp[2] = -16'sd77;
        smp[3] = -16'sd20000;
        run_mix(smp, res_l, res_r);
        check_sample("left result", res_l, smp[0]);
        check_sample("right result", res_r, smp[3]);
        finish_test();

        start_test("random mix");
        for (int i = 0; i < CHANNELS; i++) begin
            w_left[i] = coef_t'($signed(random_bits(16)) >>> 2);
            w_right[i] = coef_t'($signed(random_bits(16)) >>> 2);
        end
        load_weights(w_left, w_right);
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < CHANNELS; i++)
                smp[i] = sample_t'(random_bits(16));
            run_mix(smp, res_l, res_r);
            check_sample("left result", res_l, ref_mix(smp, w_left));
            check_sample("right result", res_r, ref_mix(smp, w_right));
        end
        finish_test();

        start_test("saturation");
        for (int i = 0; i < CHANNELS; i++) begin
            w_left[i] = 16'sh7fff;
            w_right[i] = 16'sh8000;
            smp[i] = 16'sh7fff;
        end
        load_weights(w_left, w_right);
        run_mix(smp, res_l, res_r);
        check_sample("left result", res_l, ref_mix(smp, w_left));
        check_sample("right result", res_r, ref_mix(smp, w_right));
        finish_test();

        // the mix above leaves on sd_out one frame later
        start_test("serial output");
        capture_serial(word);
        check_sample("sd_out left word", sample_t'(word[31:16]), ref_mix(smp, w_left));
        check_sample("sd_out right word", sample_t'(word[15:0]), ref_mix(smp, w_right));
        finish_test();

        start_test("status bits");
        bus_read(OFS_STATUS, word);
        check_status("status before clear", word[1:0], 2'b01);
        bus_write(OFS_CONTROL, 32'd0);
        wait_frame_start();
        wait_frame_start();
        bus_write(OFS_STATUS, 32'd1);
        bus_read(OFS_STATUS, word);
        check_status("status after clear", word[1:0], 2'b00);
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: audio_engine.sv
/*
 * audio engine top level
 * four-mic i2s capture, q1.15 stereo mix and i2s output on a host bus
 */
`timescale 1ns/1ps
`default_nettype none

module audio_engine #(
    parameter logic [31:0] ADDR    = 32'h6000,
    parameter int          DIVIDER = 2
) (
    input  wire                       ck,
    input  wire                       rst_n,
    input  wire  audio_pkg::bus_req_t bus,
    output audio_pkg::bus_rsp_t       rsp,
    input  wire                       sd_in0,
    input  wire                       sd_in1,
    output logic                      sck,
    output logic                      ws,
    output logic                      sd_out
);

    import audio_pkg::*;

    logic [4:0]             frame_posn;
    logic                   bit_edge;
    sample_t [CHANNELS-1:0] mics;
    logic                   valid0;
    logic                   valid1;
    logic                   enable;
    logic                   sample_we;
    sample_addr_t           sample_waddr;
    sample_t                sample_wdata;
    sample_addr_t           sample_raddr;
    sample_t                sample_rdata;
    logic                   coef_we;
    coef_addr_t             coef_waddr;
    coef_t                  coef_wdata;
    coef_addr_t             coef_raddr;
    coef_t                  coef_rdata;
    frame_req_t             frame_req;
    logic                   ack;
    logic                   overrun;
    logic                   done;
    mix_out_t               mix;

    i2s_clock_gen #(.DIVIDER(DIVIDER)) clk_gen_i (
        .ck(ck), .rst_n(rst_n), .sck(sck), .ws(ws),
        .frame_posn(frame_posn), .bit_edge(bit_edge));

    i2s_rx rx0_i (
        .ck(ck), .rst_n(rst_n), .bit_edge(bit_edge), .frame_posn(frame_posn),
        .sd(sd_in0), .left(mics[0]), .right(mics[1]), .sample_valid(valid0));

    i2s_rx rx1_i (
        .ck(ck), .rst_n(rst_n), .bit_edge(bit_edge), .frame_posn(frame_posn),
        .sd(sd_in1), .left(mics[2]), .right(mics[3]), .sample_valid(valid1));

    i2s_tx tx_i (
        .ck(ck), .rst_n(rst_n), .bit_edge(bit_edge), .frame_posn(frame_posn),
        .mix(mix), .sd(sd_out));

    // both receivers share frame timing
    frame_capture capture_i (
        .ck(ck), .rst_n(rst_n), .enable(enable), .sample_valid(valid0 && valid1),
        .mics(mics), .sample_we(sample_we), .sample_waddr(sample_waddr),
        .sample_wdata(sample_wdata), .frame_req(frame_req), .ack(ack),
        .overrun(overrun));

    dual_port_ram #(.entry_t(sample_t), .DEPTH(CHANNELS * FRAMES)) sample_ram_i (
        .ck(ck), .we(sample_we), .waddr(sample_waddr), .wdata(sample_wdata),
        .raddr(sample_raddr), .rdata(sample_rdata));

    dual_port_ram #(.entry_t(coef_t), .DEPTH(2 * CHANNELS)) coef_ram_i (
        .ck(ck), .we(coef_we), .waddr(coef_waddr), .wdata(coef_wdata),
        .raddr(coef_raddr), .rdata(coef_rdata));

    mix_sequencer seq_i (
        .ck(ck), .rst_n(rst_n), .frame_req(frame_req), .ack(ack),
        .sample_raddr(sample_raddr), .coef_raddr(coef_raddr),
        .sample_rdata(sample_rdata), .coef_rdata(coef_rdata),
        .mix(mix), .done(done));

    host_regs #(.ADDR(ADDR)) regs_i (
        .ck(ck), .rst_n(rst_n), .bus(bus), .rsp(rsp),
        .coef_we(coef_we), .coef_waddr(coef_waddr), .coef_wdata(coef_wdata),
        .enable(enable), .mix(mix), .done(done), .overrun(overrun));

endmodule

`default_nettype wire

// File: host_regs.sv
/*
 * host register block
 * bus decode, coefficient writes, control, status and result read-back
 */
`timescale 1ns/1ps
`default_nettype none

module host_regs #(
    parameter logic [31:0] ADDR = 32'h6000
) (
    input  wire                          ck,
    input  wire                          rst_n,
    input  wire  audio_pkg::bus_req_t    bus,
    output audio_pkg::bus_rsp_t          rsp,
    output logic                         coef_we,
    output audio_pkg::coef_addr_t        coef_waddr,
    output audio_pkg::coef_t             coef_wdata,
    output logic                         enable,
    input  wire  audio_pkg::mix_out_t    mix,
    input  wire                          done,
    input  wire                          overrun
);

    localparam logic [31:0] OFS_RESULT  = 32'h100;
    localparam logic [31:0] OFS_STATUS  = 32'h200;
    localparam logic [31:0] OFS_CONTROL = 32'h300;

    logic [31:0] offset;
    logic        access;
    logic        is_write;
    logic        hit_coef;
    logic        hit_result;
    logic        hit_status;
    logic        hit_control;
    logic [1:0]  status_q;
    logic [1:0]  status_clr;
    logic        ready_q;
    logic [31:0] rdata_q;
    logic [31:0] rdata_next;

    // high only in the first cycle of a request and ready follows it
    assign access   = bus.valid && !ready_q;
    assign is_write = |bus.wstrb;
    assign offset   = bus.addr - ADDR;

    assign hit_coef    = (offset[31:5] == '0);
    assign hit_result  = (offset[31:3] == OFS_RESULT[31:3]);
    assign hit_status  = (offset[31:2] == OFS_STATUS[31:2]);
    assign hit_control = (offset[31:2] == OFS_CONTROL[31:2]);

    assign coef_we    = access && is_write && hit_coef;
    assign coef_waddr = offset[4:2];
    assign coef_wdata = bus.wdata[15:0];

    assign status_clr = (access && is_write && hit_status) ? bus.wdata[1:0] : 2'b00;

    always_comb begin
        rdata_next = '0;
        if (!is_write) begin
            if (hit_result) begin
                if (offset[2])
                    rdata_next = {{16{mix.right[15]}}, mix.right};
                else
                    rdata_next = {{16{mix.left[15]}}, mix.left};
            end else if (hit_status) begin
                rdata_next = {30'b0, status_q};
            end else if (hit_control) begin
                rdata_next = {31'b0, enable};
            end
        end
    end

    always_ff @(posedge ck) begin
        if (access)
            rdata_q <= rdata_next;
    end

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            ready_q  <= 1'b0;
            status_q <= '0;
            enable   <= 1'b0;
        end else begin
            ready_q <= access;
            // a new event wins over a clear in the same cycle
            status_q <= (status_q & ~status_clr) | {overrun, done};
            if (access && is_write && hit_control)
                enable <= bus.wdata[0];
        end
    end

    assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: mix_sequencer.sv
/*
 * mix sequencer
 * weighted sum of the four channels for the left and right outputs,
 * fixed 12 cycle run per frame request
 */
`timescale 1ns/1ps
`default_nettype none

module mix_sequencer (
    input  wire                             ck,
    input  wire                             rst_n,
    input  wire  audio_pkg::frame_req_t     frame_req,
    output logic                            ack,
    output audio_pkg::sample_addr_t         sample_raddr,
    output audio_pkg::coef_addr_t           coef_raddr,
    input  wire  audio_pkg::sample_t        sample_rdata,
    input  wire  audio_pkg::coef_t          coef_rdata,
    output audio_pkg::mix_out_t             mix,
    output logic                            done
);

    import audio_pkg::*;

    // phases 0-3 issue reads, 1-4 accumulate, 5 finishes the output
    localparam logic [2:0] LAST_PHASE = 3'(CHANNELS + 1);

    logic       busy;
    logic       start;
    logic       out_sel;
    logic [2:0] phase;
    chan_t      chan;
    acc_t       acc;
    acc_t       prod;
    sample_t    res_left;

    // floor shift back to q15, then clamp to the sample range
    function automatic sample_t round_sat(input acc_t a);
        acc_t s;
        s = a >>> 15;
        if (s > acc_t'(32767))
            return sample_t'(16'sh7fff);
        else if (s < -acc_t'(32768))
            return sample_t'(16'sh8000);
        else
            return sample_t'(s[15:0]);
    endfunction

    assign start = frame_req.req && !ack && !busy;
    assign chan  = phase[1:0];
    assign prod  = acc_t'(sample_rdata) * acc_t'(coef_rdata);

    assign sample_raddr = {frame_req.idx, chan};
    assign coef_raddr   = {out_sel, chan};

    always_ff @(posedge ck) begin
        if (phase == 3'd1)
            acc <= prod;
        else if (phase >= 3'd2 && phase <= 3'(CHANNELS))
            acc <= acc + prod;
        if (busy && phase == LAST_PHASE && !out_sel)
            res_left <= round_sat(acc);
    end

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            out_sel <= 1'b0;
            phase   <= '0;
            ack     <= 1'b0;
            done    <= 1'b0;
            mix     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                // first reads went out this cycle
                busy  <= 1'b1;
                phase <= 3'd1;
            end else if (busy) begin
                if (phase == LAST_PHASE) begin
                    phase   <= '0;
                    out_sel <= ~out_sel;
                    if (out_sel) begin
                        busy <= 1'b0;
                        mix  <= '{left: res_left, right: round_sat(acc)};
                        done <= 1'b1;
                        ack  <= 1'b1;
                    end
                end else begin
                    phase <= phase + 3'd1;
                end
            end
            if (ack && !frame_req.req)
                ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: dual_port_ram.sv
/*
 * dual port ram
 * one write port and one registered read port, generic entry type
 */
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
    parameter type entry_t = logic [15:0],
    parameter int  DEPTH   = 16
) (
    input  wire                      ck,
    input  wire                      we,
    input  wire  [$clog2(DEPTH)-1:0] waddr,
    input  wire  entry_t             wdata,
    input  wire  [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    always_ff @(posedge ck) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // read data follows the address by one cycle
    always_ff @(posedge ck) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: frame_capture.sv
/*
 * frame capture
 * writes each received frame into the sample ring, then requests a mix
 */
`timescale 1ns/1ps
`default_nettype none

module frame_capture (
    input  wire                                              ck,
    input  wire                                              rst_n,
    input  wire                                              enable,
    input  wire                                              sample_valid,
    input  wire  audio_pkg::sample_t [audio_pkg::CHANNELS-1:0] mics,
    output logic                                             sample_we,
    output audio_pkg::sample_addr_t                          sample_waddr,
    output audio_pkg::sample_t                               sample_wdata,
    output audio_pkg::frame_req_t                            frame_req,
    input  wire                                              ack,
    output logic                                             overrun
);

    import audio_pkg::*;

    sample_t [CHANNELS-1:0] mics_q;
    chan_t                  chan;
    frame_idx_t             slot;
    frame_idx_t             req_idx;
    logic                   writing;
    logic                   req_q;
    logic                   last_write;

    assign last_write = writing && (chan == chan_t'(CHANNELS - 1));

    // frame held while the four writes go out
    always_ff @(posedge ck) begin
        if (sample_valid && enable)
            mics_q <= mics;
    end

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            writing <= 1'b0;
            chan    <= '0;
            slot    <= '0;
            req_q   <= 1'b0;
            req_idx <= '0;
            overrun <= 1'b0;
        end else begin
            overrun <= 1'b0;
            if (sample_valid && enable) begin
                writing <= 1'b1;
                chan    <= '0;
            end else if (writing) begin
                chan <= chan + chan_t'(1);
            end
            if (last_write) begin
                writing <= 1'b0;
                slot    <= slot + frame_idx_t'(1);
                // only request when the previous handshake has fully closed
                if (!req_q && !ack) begin
                    req_q   <= 1'b1;
                    req_idx <= slot;
                end else begin
                    overrun <= 1'b1;
                end
            end else if (req_q && ack) begin
                req_q <= 1'b0;
            end
        end
    end

    assign sample_we    = writing;
    assign sample_waddr = {slot, chan};
    assign sample_wdata = mics_q[chan];
    assign frame_req    = '{req: req_q, idx: req_idx};

endmodule

`default_nettype wire

// File: i2s_tx.sv
/*
 * i2s transmitter
 * sends the left and right mix results msb first on sd
 */
`timescale 1ns/1ps
`default_nettype none

module i2s_tx (
    input  wire                 ck,
    input  wire                 rst_n,
    input  wire                 bit_edge,
    input  wire  [4:0]          frame_posn,
    input  wire  audio_pkg::mix_out_t mix,
    output logic                sd
);

    logic [31:0] shift_q;

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            shift_q <= '0;
        end else if (bit_edge) begin
            // last bit just taken, so the msb of the new word is ready for position 0
            if (frame_posn == 5'd31)
                shift_q <= {mix.left, mix.right};
            else
                shift_q <= {shift_q[30:0], 1'b0};
        end
    end

    assign sd = shift_q[31];

endmodule

`default_nettype wire

// File: i2s_rx.sv
/*
 * i2s receiver
 * collects one 32-bit frame from sd and splits it into left and right
 */
`timescale 1ns/1ps
`default_nettype none

module i2s_rx (
    input  wire                ck,
    input  wire                rst_n,
    input  wire                bit_edge,
    input  wire  [4:0]         frame_posn,
    input  wire                sd,
    output audio_pkg::sample_t left,
    output audio_pkg::sample_t right,
    output logic               sample_valid
);

    logic [31:0] shift_q;
    logic [31:0] word;
    logic        last_bit;

    // word including the bit being taken now
    assign word = {shift_q[30:0], sd};
    assign last_bit = bit_edge && (frame_posn == 5'd31);

    always_ff @(posedge ck) begin
        if (bit_edge)
            shift_q <= word;
    end

    always_ff @(posedge ck) begin
        if (last_bit) begin
            left  <= word[31:16];
            right <= word[15:0];
        end
    end

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n)
            sample_valid <= 1'b0;
        else
            sample_valid <= last_bit;
    end

endmodule

`default_nettype wire

// File: i2s_clock_gen.sv
/*
 * i2s clock generator
 * divides ck down to sck and ws, tracks the bit position in the frame
 */
`timescale 1ns/1ps
`default_nettype none

module i2s_clock_gen #(
    parameter int DIVIDER = 2
) (
    input  wire        ck,
    input  wire        rst_n,
    output logic       sck,
    output logic       ws,
    output logic [4:0] frame_posn,
    output logic       bit_edge
);

    logic [7:0] div_cnt;
    logic       half_end;

    assign half_end = (div_cnt == 8'(DIVIDER - 1));

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt    <= '0;
            sck        <= 1'b0;
            frame_posn <= '0;
            bit_edge   <= 1'b0;
        end else begin
            bit_edge <= 1'b0;
            if (half_end) begin
                div_cnt <= '0;
                sck     <= ~sck;
                // rising half flags the sample point, falling half moves to the next bit
                if (!sck)
                    bit_edge <= 1'b1;
                else
                    frame_posn <= frame_posn + 5'd1;
            end else begin
                div_cnt <= div_cnt + 8'd1;
            end
        end
    end

    // low for the left word, high for the right
    assign ws = frame_posn[4];

endmodule

`default_nettype wire

// File: audio_pkg.sv
/*
 * audio peripheral shared sizes and types
 * sample, coefficient, host bus and frame handshake definitions
 */
`default_nettype none

package audio_pkg;

    localparam int CHANNELS = 4;
    localparam int FRAMES = 4;

    typedef logic signed [15:0] sample_t;
    // q1.15 mix weight
    typedef logic signed [15:0] coef_t;
    typedef logic [1:0] chan_t;
    typedef logic [1:0] frame_idx_t;
    // {slot, channel}
    typedef logic [3:0] sample_addr_t;
    // {output select, channel}
    typedef logic [2:0] coef_addr_t;
    // four 32-bit products plus headroom
    typedef logic signed [35:0] acc_t;

    typedef struct packed {
        logic        valid;
        logic [3:0]  wstrb;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic       req;
        frame_idx_t idx;
    } frame_req_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } mix_out_t;

endpackage

`default_nettype wire
